// File: include/rob_config.svh
// Sizing macros of the reorder buffer, included by the package, the RTL and the testbench
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

//////////////////////////////////////////////////
// Buffer geometry
//////////////////////////////////////////////////

// Transactions in flight, power of two
`define ROB_DEPTH 8

// Retire ports, one result bank each
`define ROB_PORT_NUM 2

// Transaction ID width, log2 of the depth
`define ROB_ID_WIDTH 3

// Width of one walk result word
`define ROB_WORD_WIDTH 16

`endif

// File: source/rob_pkg.sv
// Shared types of the reorder buffer; referenced by scoped name from every RTL block
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    // Transaction ID, wraps at the buffer depth
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;

    //////////////////////////////////////////////////
    // Result word views
    //////////////////////////////////////////////////

    // Clean walk, the word is a permission entry
    typedef struct packed {
        logic                        valid;
        logic                        read;
        logic                        write;
        logic                        exec;
        // Table address tag fills the rest
        logic [`ROB_WORD_WIDTH-5:0]  tag;
    } rob_perm_t;

    // Faulted walk, the word is a fault record
    typedef struct packed {
        logic [3:0]                  code;
        // Level where the walk stopped
        logic [1:0]                  level;
        logic [`ROB_WORD_WIDTH-7:0]  rsvd;
    } rob_fault_t;

    // Same bits, view picked by the fault flag beside the word
    typedef union packed {
        rob_perm_t   perm;
        rob_fault_t  fault;
    } rob_result_u;

endpackage

`default_nettype wire

// File: source/rob_id_allocator.sv
// Hands out in-order transaction IDs to issue requests and pushes them into the order queue
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_id_allocator (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic             issue_req_i,
    input  wire logic             fifo_full_i,
    input  wire logic             flush_active_i,
    input  wire logic             flush_clear_i,
    output logic                  push_o,
    output rob_pkg::rob_id_t      push_id_o,
    output rob_pkg::rob_id_t      issue_id_o,
    output logic                  issue_grant_o
);

    // Next ID to hand out
    rob_pkg::rob_id_t next_id_q;
    logic             accept;

    // Only place where fullness and flush gate an issue
    // A request while full or flushing is simply dropped
    assign accept = issue_req_i && !fifo_full_i && !flush_active_i;

    // Queue push happens in the request cycle
    assign push_o    = accept;
    assign push_id_o = next_id_q;

    // Counter wraps by width, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_ni || flush_clear_i) begin
            next_id_q <= '0;
        end else if (accept) begin
            next_id_q <= next_id_q + 1'b1;
        end
    end

    // Grant strobe, one cycle after the request
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            issue_grant_o <= 1'b0;
        end else begin
            issue_grant_o <= accept;
        end
    end

    // ID beside the grant, only meaningful with it
    always_ff @(posedge clk_i) begin
        if (accept) begin
            issue_id_o <= next_id_q;
        end
    end

endmodule

`default_nettype wire

// File: source/rob_order_fifo.sv
// Circular queue of granted IDs in issue order; the head is the eldest uncommitted ID
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_order_fifo (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              push_i,
    input  wire logic              pop_i,
    input  wire logic              clear_i,
    input  wire rob_pkg::rob_id_t  push_id_i,
    output rob_pkg::rob_id_t       head_id_o,
    output logic                   empty_o,
    output logic                   full_o
);

    // ID storage
    rob_pkg::rob_id_t id_mem [`ROB_DEPTH];

    // Pointers wrap by width
    logic [`ROB_ID_WIDTH-1:0] wr_ptr_q;
    logic [`ROB_ID_WIDTH-1:0] rd_ptr_q;
    // One extra bit so a full queue is distinct from empty
    logic [`ROB_ID_WIDTH:0]   count_q;

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    // Callers never push when full nor pop when empty
    always_ff @(posedge clk_i) begin
        if (!rst_ni || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the count as it is
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage write, contents are don't care until pushed
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            id_mem[wr_ptr_q] <= push_id_i;
        end
    end

    //////////////////////////////////////////////////
    // Status and head
    //////////////////////////////////////////////////

    assign head_id_o = id_mem[rd_ptr_q];
    assign empty_o   = (count_q == '0);
    assign full_o    = (count_q == (`ROB_ID_WIDTH+1)'(`ROB_DEPTH));

endmodule

`default_nettype wire

// File: source/rob_result_bank.sv
// Per-port result register file indexed by ID, with retire write, head read and clears
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_result_bank (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 clear_all_i,
    input  wire logic                 wr_en_i,
    input  wire rob_pkg::rob_id_t     wr_id_i,
    input  wire logic                 wr_fault_i,
    input  wire rob_pkg::rob_result_u wr_result_i,
    input  wire rob_pkg::rob_id_t     rd_id_i,
    input  wire logic                 rd_clear_i,
    output logic                      done_o,
    output logic                      rd_fault_o,
    output rob_pkg::rob_result_u      rd_result_o
);

    // Done bit per entry, the only control state here
    logic [`ROB_DEPTH-1:0] done_q;

    // Payload per entry
    logic [`ROB_DEPTH-1:0] fault_q;
    rob_pkg::rob_result_u  result_q [`ROB_DEPTH];

    //////////////////////////////////////////////////
    // Done bits
    //////////////////////////////////////////////////

    // Flush wipes every entry and drops a same-cycle write
    always_ff @(posedge clk_i) begin
        if (!rst_ni || clear_all_i) begin
            done_q <= '0;
        end else begin
            // Committed entry is released
            if (rd_clear_i) begin
                done_q[rd_id_i] <= 1'b0;
            end
            // A retire marks its entry, written after the clear
            if (wr_en_i) begin
                done_q[wr_id_i] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en_i && !clear_all_i) begin
            fault_q[wr_id_i]  <= wr_fault_i;
            result_q[wr_id_i] <= wr_result_i;
        end
    end

    // Combinational read at the head ID
    assign done_o      = done_q[rd_id_i];
    assign rd_fault_o  = fault_q[rd_id_i];
    assign rd_result_o = result_q[rd_id_i];

endmodule

`default_nettype wire

// File: source/rob_commit_ctrl.sv
// Releases the eldest entry once a bank holds its result and drives the decoded commit
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module rob_commit_ctrl (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 fifo_empty_i,
    input  wire logic                 flush_active_i,
    input  wire rob_pkg::rob_id_t     head_id_i,
    input  wire logic [`ROB_PORT_NUM-1:0] bank_done_i,
    input  wire logic [`ROB_PORT_NUM-1:0] bank_fault_i,
    input  wire rob_pkg::rob_result_u bank_result_i [`ROB_PORT_NUM],
    output logic                      pop_o,
    output logic                      commit_valid_o,
    output logic                      commit_fault_o,
    output rob_pkg::rob_id_t          commit_id_o,
    output logic [2:0]                commit_perm_o,
    output logic [3:0]                commit_fault_code_o
);

    // Result picked from the banks
    logic                 sel_fault;
    rob_pkg::rob_result_u sel_result;

    //////////////////////////////////////////////////
    // Bank select and pop decision
    //////////////////////////////////////////////////

    // Highest port index with the head done wins
    always_comb begin
        sel_fault  = 1'b0;
        sel_result = '0;
        for (int p = 0; p < `ROB_PORT_NUM; p++) begin
            if (bank_done_i[p]) begin
                sel_fault  = bank_fault_i[p];
                sel_result = bank_result_i[p];
            end
        end
    end

    // Pop also clears the head entry in every bank
    assign pop_o = !fifo_empty_i && !flush_active_i && (|bank_done_i);

    //////////////////////////////////////////////////
    // Registered commit
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= pop_o;
        end
    end

    // Word decoded through the view the fault flag selects
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            commit_id_o    <= head_id_i;
            commit_fault_o <= sel_fault;
            if (sel_fault) begin
                commit_perm_o       <= 3'b000;
                commit_fault_code_o <= sel_result.fault.code;
            end else begin
                commit_perm_o       <= {sel_result.perm.read,
                                        sel_result.perm.write,
                                        sel_result.perm.exec};
                commit_fault_code_o <= 4'h0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rob_flush_ctrl.sv
// Flush-all sequencer giving the clear pulse, the busy window and the done status
`timescale 1ns/1ns
`default_nettype none

module rob_flush_ctrl (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  flush_i,
    output logic       flush_clear_o,
    output logic       flush_active_o,
    output logic       flush_done_o
);

    typedef enum logic [1:0] {
        FLUSH_RUN,
        FLUSH_CLEAR,
        FLUSH_WAIT
    } flush_state_e;

    flush_state_e state_q;
    flush_state_e state_cur;
    flush_state_e state_d;

    // First cycle with flush_i high is the clear cycle itself
    // so the clear state is entered without a register stage
    assign state_cur = (state_q == FLUSH_RUN && flush_i) ? FLUSH_CLEAR : state_q;

    always_comb begin
        state_d = state_cur;
        case (state_cur)
            FLUSH_RUN:   state_d = FLUSH_RUN;
            // One clear cycle, then hold done
            FLUSH_CLEAR: state_d = FLUSH_WAIT;
            // Stay until the request drops
            FLUSH_WAIT:  state_d = flush_i ? FLUSH_WAIT : FLUSH_RUN;
            default:     state_d = FLUSH_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= FLUSH_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Outputs
    assign flush_clear_o  = (state_cur == FLUSH_CLEAR);
    assign flush_active_o = (state_cur != FLUSH_RUN);
    assign flush_done_o   = (state_cur == FLUSH_WAIT);

endmodule

`default_nettype wire

// File: source/retire_stage.sv
// Reorder buffer of the walker retire stage; top level joining issue, retire and commit sides
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module retire_stage (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    // Issue side
    input  wire logic                     issue_req_i,
    output logic                          issue_grant_o,
    output rob_pkg::rob_id_t              issue_id_o,
    output logic                          rob_full_o,
    // Retire ports
    input  wire logic [`ROB_PORT_NUM-1:0] retire_valid_i,
    input  wire rob_pkg::rob_id_t         retire_id_i [`ROB_PORT_NUM],
    input  wire logic [`ROB_PORT_NUM-1:0] retire_fault_i,
    input  wire rob_pkg::rob_result_u     retire_result_i [`ROB_PORT_NUM],
    // Commit side
    output logic                          commit_valid_o,
    output rob_pkg::rob_id_t              commit_id_o,
    output logic                          commit_fault_o,
    output logic [2:0]                    commit_perm_o,
    output logic [3:0]                    commit_fault_code_o,
    // Flush control and status
    input  wire logic                     flush_i,
    output logic                          flush_done_o
);

    // Flush
    logic flush_clear;
    logic flush_active;

    // Order queue
    logic             fifo_push;
    logic             fifo_pop;
    logic             fifo_empty;
    rob_pkg::rob_id_t fifo_push_id;
    rob_pkg::rob_id_t head_id;

    // Bank read side, one lane per port
    logic [`ROB_PORT_NUM-1:0] bank_done;
    logic [`ROB_PORT_NUM-1:0] bank_fault;
    rob_pkg::rob_result_u     bank_result [`ROB_PORT_NUM];

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    rob_flush_ctrl i_rob_flush_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .flush_clear_o  (flush_clear),
        .flush_active_o (flush_active),
        .flush_done_o   (flush_done_o)
    );

    rob_id_allocator i_rob_id_allocator (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .issue_req_i    (issue_req_i),
        .fifo_full_i    (rob_full_o),
        .flush_active_i (flush_active),
        .flush_clear_i  (flush_clear),
        .push_o         (fifo_push),
        .push_id_o      (fifo_push_id),
        .issue_id_o     (issue_id_o),
        .issue_grant_o  (issue_grant_o)
    );

    // Full status comes straight from the queue occupancy
    rob_order_fifo i_rob_order_fifo (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (fifo_push),
        .pop_i     (fifo_pop),
        .clear_i   (flush_clear),
        .push_id_i (fifo_push_id),
        .head_id_o (head_id),
        .empty_o   (fifo_empty),
        .full_o    (rob_full_o)
    );

    //////////////////////////////////////////////////
    // Result banks
    //////////////////////////////////////////////////

    // Retire writes are dropped for the whole flush window
    for (genvar p = 0; p < `ROB_PORT_NUM; p++) begin : gen_bank
        rob_result_bank i_rob_result_bank (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .clear_all_i (flush_clear),
            .wr_en_i     (retire_valid_i[p] & ~flush_active),
            .wr_id_i     (retire_id_i[p]),
            .wr_fault_i  (retire_fault_i[p]),
            .wr_result_i (retire_result_i[p]),
            .rd_id_i     (head_id),
            .rd_clear_i  (fifo_pop),
            .done_o      (bank_done[p]),
            .rd_fault_o  (bank_fault[p]),
            .rd_result_o (bank_result[p])
        );
    end

    //////////////////////////////////////////////////
    // Commit
    //////////////////////////////////////////////////

    rob_commit_ctrl i_rob_commit_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .fifo_empty_i        (fifo_empty),
        .flush_active_i      (flush_active),
        .head_id_i           (head_id),
        .bank_done_i         (bank_done),
        .bank_fault_i        (bank_fault),
        .bank_result_i       (bank_result),
        .pop_o               (fifo_pop),
        .commit_valid_o      (commit_valid_o),
        .commit_fault_o      (commit_fault_o),
        .commit_id_o         (commit_id_o),
        .commit_perm_o       (commit_perm_o),
        .commit_fault_code_o (commit_fault_code_o)
    );

endmodule

`default_nettype wire

// File: verification/retire_stage_tb.sv
// Testbench of the reorder buffer; drives LFSR stimulus into the retire stage and checks it
`timescale 1ns/1ns
`default_nettype none

`include "rob_config.svh"

module retire_stage_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PORT_W       = $clog2(`ROB_PORT_NUM);
    localparam int RANDOM_CYCLES = 1500;
    // Limit about twice the length of all tests together
    localparam int TIMEOUT_CYCLES = 4000;

    // DUT ports
    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     issue_req_i;
    logic                     issue_grant_o;
    rob_pkg::rob_id_t         issue_id_o;
    logic                     rob_full_o;
    logic [`ROB_PORT_NUM-1:0] retire_valid_i;
    rob_pkg::rob_id_t         retire_id_i [`ROB_PORT_NUM];
    logic [`ROB_PORT_NUM-1:0] retire_fault_i;
    rob_pkg::rob_result_u     retire_result_i [`ROB_PORT_NUM];
    logic                     commit_valid_o;
    rob_pkg::rob_id_t         commit_id_o;
    logic                     commit_fault_o;
    logic [2:0]               commit_perm_o;
    logic [3:0]               commit_fault_code_o;
    logic                     flush_i;
    logic                     flush_done_o;

    // Driver side bookkeeping
    logic [15:0]              lfsr_q = 16'd3911;
    string                    test_name;
    rob_pkg::rob_id_t         unretired_q [$];
    logic                     sent_fault [`ROB_DEPTH];
    logic [`ROB_WORD_WIDTH-1:0] sent_word [`ROB_DEPTH];
    int                       retire_count [`ROB_DEPTH];

    // Model kept by the monitor
    rob_pkg::rob_id_t         grant_q [$];
    rob_pkg::rob_id_t         exp_next_id;
    logic                     exp_grant;
    logic                     prev_flush;
    int                       commit_count [`ROB_DEPTH];
    int                       cycle_count;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    retire_stage i_retire_stage (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .issue_req_i         (issue_req_i),
        .issue_grant_o       (issue_grant_o),
        .issue_id_o          (issue_id_o),
        .rob_full_o          (rob_full_o),
        .retire_valid_i      (retire_valid_i),
        .retire_id_i         (retire_id_i),
        .retire_fault_i      (retire_fault_i),
        .retire_result_i     (retire_result_i),
        .commit_valid_o      (commit_valid_o),
        .commit_id_o         (commit_id_o),
        .commit_fault_o      (commit_fault_o),
        .commit_perm_o       (commit_perm_o),
        .commit_fault_code_o (commit_fault_code_o),
        .flush_i             (flush_i),
        .flush_done_o        (flush_done_o)
    );

    //////////////////////////////////////////////////
    // Reference, random source and failure handling
    //////////////////////////////////////////////////

    // Expected {perm, code} of one commit
    // Clean word gives R/W/X just below the valid bit
    // Faulted word gives the code in the top four bits
    function automatic logic [6:0] expected_commit(input logic fault,
                                                   input logic [`ROB_WORD_WIDTH-1:0] word);
        if (fault) begin
            return {3'b000, word[`ROB_WORD_WIDTH-1:`ROB_WORD_WIDTH-4]};
        end else begin
            return {word[`ROB_WORD_WIDTH-2:`ROB_WORD_WIDTH-4], 4'h0};
        end
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
        return value;
    endfunction

    task automatic end_in_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic abort_with_message(input string msg);
        $display("%s", msg);
        end_in_failure();
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: test %s, %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            end_in_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Inputs change 1 ns after the edge
    // New grants join the retire pool
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        if (issue_grant_o) begin
            unretired_q.push_back(issue_id_o);
        end
    endtask

    task automatic clear_strobes();
        issue_req_i    = 1'b0;
        retire_valid_i = '0;
    endtask

    // Given fault flag and word for one ID on one port
    task automatic retire_word(input logic [PORT_W-1:0] port, input rob_pkg::rob_id_t id,
                               input logic fault, input logic [`ROB_WORD_WIDTH-1:0] word);
        retire_valid_i[port]  = 1'b1;
        retire_id_i[port]     = id;
        retire_fault_i[port]  = fault;
        retire_result_i[port] = word;
        sent_fault[id]        = fault;
        sent_word[id]         = word;
        retire_count[id]++;
    endtask

    // Random fault flag and word for one ID on one port
    task automatic retire_on(input logic [PORT_W-1:0] port, input rob_pkg::rob_id_t id);
        logic [31:0] bits;
        bits = rand_bits(`ROB_WORD_WIDTH + 1);
        retire_word(port, id, bits[`ROB_WORD_WIDTH], bits[`ROB_WORD_WIDTH-1:0]);
    endtask

    // Maybe a request, and on each port maybe a shuffled retire
    task automatic random_cycle(input logic allow_issue);
        logic [31:0] bits;
        int          idx;
        rob_pkg::rob_id_t id;
        clear_strobes();
        if (allow_issue) begin
            bits        = rand_bits(1);
            issue_req_i = bits[0];
        end
        for (int p = 0; p < `ROB_PORT_NUM; p++) begin
            bits = rand_bits(1);
            if (bits[0] && unretired_q.size() > 0) begin
                bits = rand_bits(3);
                idx  = int'(bits) % unretired_q.size();
                id   = unretired_q[idx];
                unretired_q.delete(idx);
                retire_on(PORT_W'(p), id);
            end
        end
        next_cycle();
    endtask

    task automatic drain();
        do begin
            random_cycle(1'b0);
        end while (grant_q.size() != 0);
    endtask

    task automatic wait_for_commit();
        while (commit_valid_o !== 1'b1) begin
            next_cycle();
        end
    endtask

    //////////////////////////////////////////////////
    // Monitor and model
    //////////////////////////////////////////////////

    // Samples at the falling edge where outputs and inputs are settled
    initial begin : monitor
        rob_pkg::rob_id_t exp_id;
        logic [6:0]       exp_decode;
        logic             exp_full;
        exp_grant     = 1'b0;
        prev_flush    = 1'b0;
        exp_next_id   = '0;
        cycle_count   = 0;
        commit_count  = '{default: 0};
        forever begin
            @(negedge clk_i);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                abort_with_message($sformatf("Run did not finish within %0d cycles",
                                             TIMEOUT_CYCLES));
            end
            if (!rst_ni) begin
                exp_grant   = 1'b0;
                prev_flush  = 1'b0;
                exp_next_id = '0;
                grant_q.delete();
            end else begin
                // Grant for the request seen one cycle back
                compare_value("issue_grant_o", 32'(exp_grant), 32'(issue_grant_o));
                if (issue_grant_o) begin
                    compare_value("issue_id_o", 32'(exp_next_id), 32'(issue_id_o));
                    grant_q.push_back(exp_next_id);
                    exp_next_id = exp_next_id + 1'b1;
                end
                // Commits come in grant order and only after the result was sent
                if (commit_valid_o) begin
                    if (grant_q.size() == 0) begin
                        abort_with_message("Commit strobe while no entry was outstanding");
                    end else begin
                        exp_id = grant_q.pop_front();
                        compare_value("commit_id_o", 32'(exp_id), 32'(commit_id_o));
                        if (retire_count[exp_id] == commit_count[exp_id]) begin
                            abort_with_message($sformatf(
                                "ID %0d committed before its result was retired", exp_id));
                        end
                        commit_count[exp_id]++;
                        exp_decode = expected_commit(sent_fault[exp_id], sent_word[exp_id]);
                        compare_value("commit_fault_o", 32'(sent_fault[exp_id]),
                                      32'(commit_fault_o));
                        compare_value("commit_perm_o", 32'(exp_decode[6:4]),
                                      32'(commit_perm_o));
                        compare_value("commit_fault_code_o", 32'(exp_decode[3:0]),
                                      32'(commit_fault_code_o));
                    end
                end
                exp_full = (grant_q.size() == `ROB_DEPTH);
                compare_value("rob_full_o", 32'(exp_full), 32'(rob_full_o));
                // Done trails the flush request by one cycle
                compare_value("flush_done_o", 32'(prev_flush), 32'(flush_done_o));
                exp_grant = issue_req_i && !exp_full && !flush_i && !prev_flush;
                // Clear cycle empties everything and drops retired but uncommitted results
                if (flush_i && !prev_flush) begin
                    grant_q.delete();
                    exp_next_id  = '0;
                    commit_count = retire_count;
                end
                prev_flush = flush_i;
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : driver
        logic [31:0] bits;
        rob_pkg::rob_id_t id;
        rst_ni          = 1'b0;
        issue_req_i     = 1'b0;
        flush_i         = 1'b0;
        retire_valid_i  = '0;
        retire_fault_i  = '0;
        retire_id_i     = '{default: '0};
        retire_result_i = '{default: '0};
        retire_count    = '{default: 0};
        test_name       = "reset";
        repeat (RESET_CYCLES) next_cycle();
        rst_ni = 1'b1;
        next_cycle();

        // Back to back requests with IDs from 0
        test_name = "allocation";
        repeat (`ROB_DEPTH) begin
            issue_req_i = 1'b1;
            next_cycle();
        end

        // No retirement yet, so the buffer is full
        test_name = "full";
        compare_value("rob_full_o", 32'd1, 32'(rob_full_o));
        issue_req_i = 1'b1;
        next_cycle();
        issue_req_i = 1'b0;
        compare_value("grant while full", 32'd0, 32'(issue_grant_o));
        id = unretired_q.pop_front();
        retire_on('0, id);
        next_cycle();
        clear_strobes();
        wait_for_commit();
        compare_value("rob_full_o after commit", 32'd0, 32'(rob_full_o));
        issue_req_i = 1'b1;
        next_cycle();
        issue_req_i = 1'b0;
        compare_value("grant after commit", 32'd1, 32'(issue_grant_o));
        compare_value("wrapped id", 32'd0, 32'(issue_id_o));
        drain();

        test_name = "out of order";
        repeat (RANDOM_CYCLES) random_cycle(1'b1);
        drain();

        // One faulted and one clean word with known decodes
        test_name = "result views";
        repeat (2) begin
            issue_req_i = 1'b1;
            next_cycle();
        end
        issue_req_i = 1'b0;
        // Fault code 5 on top, the permission view would read 3'b101
        id = unretired_q.pop_front();
        retire_word('0, id, 1'b1, 16'h5FFF);
        next_cycle();
        clear_strobes();
        // Valid, read and write set, the fault view would read code 0xE
        id = unretired_q.pop_front();
        retire_word('0, id, 1'b0, 16'hE000);
        next_cycle();
        clear_strobes();
        wait_for_commit();
        compare_value("faulted perm", 32'd0, 32'(commit_perm_o));
        compare_value("faulted code", 32'h5, 32'(commit_fault_code_o));
        next_cycle();
        wait_for_commit();
        compare_value("clean perm", 32'b110, 32'(commit_perm_o));
        compare_value("clean code", 32'd0, 32'(commit_fault_code_o));
        drain();

        // Retire all but the eldest so nothing can commit before the flush
        test_name = "flush";
        repeat (6) begin
            issue_req_i = 1'b1;
            next_cycle();
        end
        issue_req_i = 1'b0;
        while (unretired_q.size() > 1) begin
            clear_strobes();
            bits = rand_bits(PORT_W);
            retire_on(bits[PORT_W-1:0], unretired_q.pop_back());
            next_cycle();
        end
        clear_strobes();
        flush_i     = 1'b1;
        issue_req_i = 1'b1;
        repeat (5) begin
            next_cycle();
            compare_value("flush_done_o", 32'd1, 32'(flush_done_o));
            compare_value("grant during flush", 32'd0, 32'(issue_grant_o));
        end
        flush_i     = 1'b0;
        issue_req_i = 1'b0;
        next_cycle();
        compare_value("flush_done_o after release", 32'd0, 32'(flush_done_o));
        unretired_q.delete();
        repeat (4) next_cycle();
        issue_req_i = 1'b1;
        next_cycle();
        issue_req_i = 1'b0;
        compare_value("grant after flush", 32'd1, 32'(issue_grant_o));
        compare_value("id after flush", 32'd0, 32'(issue_id_o));
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/rob_pkg.sv
source/rob_id_allocator.sv
source/rob_order_fifo.sv
source/rob_result_bank.sv
source/rob_commit_ctrl.sv
source/rob_flush_ctrl.sv
source/retire_stage.sv
verification/retire_stage_tb.sv

// File: Makefile
# Verilator build and run of the retire stage testbench

obj_dir/Vretire_stage_tb: sources.f include/rob_config.svh $(filter-out +incdir+%,$(shell cat sources.f))
	verilator --binary --timing -j 0 --top-module retire_stage_tb -f sources.f

run: obj_dir/Vretire_stage_tb
	@out="$$(./obj_dir/Vretire_stage_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
